//--- compile.f
+incdir+logic
+incdir+verif
logic/interp_pkg.sv
logic/sample_capture.sv
logic/sample_fifo.sv
logic/linear_interp.sv
logic/upsampler_top.sv
verif/upsampler_tb.sv

//--- Bender.yml
package:
  name: upsampler

sources:
  - include_dirs:
      - logic
    files:
      - logic/interp_pkg.sv
      - logic/sample_capture.sv
      - logic/sample_fifo.sv
      - logic/linear_interp.sv
      - logic/upsampler_top.sv
  - target: simulation
    include_dirs:
      - logic
      - verif
    files:
      - verif/upsampler_tb.sv

//--- verif/upsampler_tests.svh
`ifndef UPSAMPLER_TESTS_SVH
`define UPSAMPLER_TESTS_SVH

// zero state, then underrun on the 16th edge with no input
task automatic check_after_reset();
	int edges;
	apply_reset();
	check_equal("interp_o", int'(interp_o), 0);
	check_equal("overflow", overflow, 0);
	check_equal("underrun", underrun, 0);
	edges = 0;
	while (!underrun && edges < 32) begin
		tick();
		edges++;
	end
	check_equal("underrun_edge", edges, 16);
endtask

// one sample per frame, same value
task automatic hold_constant(input in_sample_t val);
	apply_reset();
	repeat (4) begin
		wait_count(2);
		send_sample(val);
	end
	// pair is (val, val) by now, step zero
	wait_count(15);
	repeat (16) begin
		check_equal("interp_o", int'(interp_o), scaled(val));
		tick();
	end
endtask

// a then b, check the frame that ramps from a to b
task automatic ramp_between(input in_sample_t a, input in_sample_t b);
	int delta;
	int prev;
	// step per clock in output units
	delta = (((int'(b) - int'(a)) * 256) >>> `STEP_SHIFT) >>> 4;
	apply_reset();
	wait_count(2);
	send_sample(a);
	wait_count(2);
	send_sample(b);
	// b popped at the end of frame 1
	wait_count(15);
	tick();
	tick();
	// reload shows one clock after the boundary
	check_equal("interp_o", int'(interp_o), scaled(a));
	prev = int'(interp_o);
	repeat (15) begin
		tick();
		check_equal("interp_o_step", int'(interp_o) - prev, delta);
		prev = int'(interp_o);
	end
	tick();
	check_equal("interp_o", int'(interp_o), scaled(b));
endtask

// one random sample per frame at a random slot
task automatic jitter_arrival(input int frames);
	int pos;
	apply_reset();
	repeat (frames) begin
		// slot 13 is the last one popped in the same frame
		pos = $urandom_range(13, 0);
		wait_count(pos);
		send_sample(in_sample_t'($urandom));
		// the late slot already ends on the boundary cycle
		if (m_cnt != 15) begin
			wait_count(15);
		end
	end
	check_equal("overflow", overflow, 0);
	check_equal("underrun", underrun, 0);
	repeat (3) wait_count(15);
	check_equal("overflow", overflow, 0);
endtask

// six strobes two clocks apart into a 4 deep fifo
task automatic fill_past_depth();
	in_sample_t vals [6];
	vals = '{in_sample_t'(30), in_sample_t'(-70), in_sample_t'(90),
		in_sample_t'(-10), in_sample_t'(55), in_sample_t'(-99)};
	apply_reset();
	foreach (vals[i]) begin
		send_sample(vals[i]);
	end
	check_equal("overflow", overflow, 1);
	// four kept samples drain, then the output sits at the 4th
	repeat (6) wait_count(15);
	check_equal("interp_o", int'(interp_o), scaled(vals[3]));
	check_equal("overflow", overflow, 1);
endtask

// ramp, stop input, output goes flat at the last sample
task automatic starve_input();
	int waited;
	in_sample_t last;
	last = in_sample_t'(-77);
	apply_reset();
	wait_count(3);
	send_sample(in_sample_t'(40));
	wait_count(3);
	send_sample(last);
	check_equal("underrun", underrun, 0);
	waited = 0;
	while (!underrun && waited < 64) begin
		tick();
		waited++;
	end
	if (!underrun) begin
		$display("underrun never set after input stopped");
		$display("RESULT: FAIL");
		$fatal(1, "stopping on missing underrun");
	end
	// acc reloaded with last on that boundary
	tick();
	repeat (16) begin
		check_equal("interp_o", int'(interp_o), scaled(last));
		tick();
	end
endtask

`endif

//--- verif/upsampler_tb.sv
`timescale 1ns/10ps

`include "interp_cfg.svh"

module upsampler_tb;

	import interp_pkg::*;

	// rough length of all tests in clocks
	// reset and smoke 25, constants 170, ramps 180, jitter 700, overflow 110, underrun 75
	localparam int TEST_CYCLES = 1300;
	// run is cut off half again past that
	localparam int MAX_CYCLES = TEST_CYCLES * 3 / 2;

	logic        clock;
	logic        reset;
	in_sample_t  v_in;
	logic        sample_valid;
	out_sample_t interp_o;
	logic        overflow;
	logic        underrun;

	// reference model state
	// capture stage
	bit      m_wr_pend;
	sample_t m_wr_val;
	// fifo contents, head first
	sample_t m_queue [$];
	// interpolator
	int      m_cnt;
	sample_t m_v;
	sample_t m_v_prev;
	sample_t m_acc;
	out_sample_t m_out;
	bit      m_over;
	bit      m_under;
	// model has seen at least one reset edge
	bit      m_live;

	int cycle_cnt;

	upsampler_top upsampler_i (
		.clock        (clock),
		.reset        (reset),
		.v_in         (v_in),
		.sample_valid (sample_valid),
		.interp_o     (interp_o),
		.overflow     (overflow),
		.underrun     (underrun)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// one clock of the whole datapath per rising edge
	always @(posedge clock) begin : ref_model
		int step;
		bit was_full;
		if (reset) begin
			m_queue.delete();
			m_wr_pend = 1'b0;
			m_cnt     = 0;
			m_v       = '0;
			m_v_prev  = '0;
			m_acc     = '0;
			m_out     = '0;
			m_over    = 1'b0;
			m_under   = 1'b0;
			m_live    = 1'b1;
		end
		else begin
			// full as seen before this edge
			was_full = (m_queue.size() == `FIFO_DEPTH);
			// sample difference over the frame length
			step = (int'(m_v) - int'(m_v_prev)) >>> `STEP_SHIFT;
			// output register takes the top bits
			m_out = out_sample_t'(m_acc >>> (`I_BITS - `OUT_BITS));
			if (m_cnt == (1 << `STEP_SHIFT) - 1) begin
				m_acc    = m_v;
				m_v_prev = m_v;
				if (m_queue.size() != 0) begin
					m_v = m_queue.pop_front();
				end
				else begin
					// v holds, so the next step is zero
					m_under = 1'b1;
				end
			end
			else begin
				m_acc = m_acc + sample_t'(step);
			end
			// write lands after any pop on the same edge
			if (m_wr_pend) begin
				if (was_full) begin
					m_over = 1'b1;
				end
				else begin
					m_queue.push_back(m_wr_val);
				end
			end
			m_wr_pend = sample_valid;
			if (sample_valid) begin
				m_wr_val = sample_t'(int'(v_in) <<< (`I_BITS - `IN_BITS));
			end
			m_cnt = (m_cnt + 1) % (1 << `STEP_SHIFT);
		end
	end

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
			$display("RESULT: FAIL");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// outputs are stable between edges
	always @(negedge clock) begin
		if (m_live) begin
			check_equal("interp_o", int'(interp_o), int'(m_out));
			check_equal("overflow", overflow, m_over);
			check_equal("underrun", underrun, m_under);
		end
	end

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "stopping on timeout");
		end
	end

	task automatic tick();
		@(negedge clock);
	endtask

	// four rising edges with reset high
	task automatic apply_reset();
		tick();
		reset = 1'b1;
		sample_valid = 1'b0;
		repeat (4) tick();
		reset = 1'b0;
	endtask

	// one-cycle strobe, then one idle cycle
	task automatic send_sample(input in_sample_t s);
		v_in = s;
		sample_valid = 1'b1;
		tick();
		sample_valid = 1'b0;
		tick();
	endtask

	// moves on at least one cycle
	task automatic wait_count(input int pos);
		do begin
			tick();
		end while (m_cnt != pos);
	endtask

	// input sample as it shows on interp_o, 8 bits up then top 12 of 16
	function automatic int scaled(input in_sample_t s);
		return int'(s) * 16;
	endfunction

	`include "upsampler_tests.svh"

	initial begin
		void'($urandom(32'hb997));
		cycle_cnt = 0;
		reset = 1'b1;
		sample_valid = 1'b0;
		v_in = '0;
		check_after_reset();
		hold_constant(in_sample_t'(100));
		hold_constant(in_sample_t'(-57));
		ramp_between(in_sample_t'(-128), in_sample_t'(127));
		ramp_between(in_sample_t'(127), in_sample_t'(-128));
		ramp_between(in_sample_t'(20), in_sample_t'(-45));
		jitter_arrival(40);
		fill_past_depth();
		starve_input();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- logic/upsampler_top.sv
`timescale 1ns/10ps

`include "interp_cfg.svh"

module upsampler_top (
	input  logic                    clock,
	input  logic                    reset,
	input  interp_pkg::in_sample_t  v_in,
	input  logic                    sample_valid,
	output interp_pkg::out_sample_t interp_o,
	output logic                    overflow,
	output logic                    underrun
);

	import interp_pkg::*;

	// capture to fifo
	logic    wr_en;
	sample_t wr_data;
	logic    full;

	// fifo to interpolator
	logic    rd_en;
	sample_t rd_data;
	logic    empty;

	// strobed input, aligned and written one cycle later
	sample_capture sample_capture_i (
		.clock        (clock),
		.reset        (reset),
		.v_in         (v_in),
		.sample_valid (sample_valid),
		.full         (full),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.overflow     (overflow)
	);

	// absorbs jitter in sample arrival
	sample_fifo #(
		.DEPTH (`FIFO_DEPTH)
	) sample_fifo_i (
		.clock   (clock),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_data (rd_data),
		.full    (full),
		.empty   (empty)
	);

	// one output per clock, ramping between samples
	linear_interp linear_interp_i (
		.clock    (clock),
		.reset    (reset),
		.rd_data  (rd_data),
		.empty    (empty),
		.rd_en    (rd_en),
		.interp_o (interp_o),
		.underrun (underrun)
	);

endmodule

//--- logic/linear_interp.sv
`timescale 1ns/10ps

`include "interp_cfg.svh"

module linear_interp (
	input  logic                    clock,
	input  logic                    reset,
	input  interp_pkg::sample_t     rd_data,
	input  logic                    empty,
	output logic                    rd_en,
	output interp_pkg::out_sample_t interp_o,
	output logic                    underrun
);

	import interp_pkg::*;

	// last count of a frame, the boundary
	localparam logic [`STEP_SHIFT-1:0] FRAME_LAST = '1;

	// free-running frame counter
	logic [`STEP_SHIFT-1:0] frame_cnt;
	logic boundary;

	// newest and previous held samples
	sample_t v;
	sample_t v_prev;

	// ramp accumulator
	sample_t acc;

	// difference is one bit wider so a full-scale jump
	// such as -128 to 127 does not wrap
	logic signed [`I_BITS:0] diff;
	logic signed [`I_BITS:0] diff_shr;
	// per-cycle increment
	sample_t step;

	assign boundary = (frame_cnt == FRAME_LAST);

	// pop at the boundary only when something is waiting
	assign rd_en = boundary && !empty;

	// operands sign-extend to the wider result
	assign diff = v - v_prev;
	// divide by the upsample factor
	assign diff_shr = diff >>> `STEP_SHIFT;
	// fits back into the internal width after the shift
	assign step = diff_shr[`I_BITS-1:0];

	// wraps on its own after FRAME_LAST
	always_ff @(posedge clock) begin
		if (reset) begin
			frame_cnt <= '0;
		end
		else begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// sample pair shifts at each boundary
	// with no new sample v holds, v_prev catches up and the step goes to zero
	always_ff @(posedge clock) begin
		if (reset) begin
			v      <= '0;
			v_prev <= '0;
		end
		else if (boundary) begin
			v_prev <= v;
			if (!empty) begin
				v <= rd_data;
			end
		end
	end

	// reload with the newer sample, then ramp towards the next one
	always_ff @(posedge clock) begin
		if (reset) begin
			acc <= '0;
		end
		else if (boundary) begin
			acc <= v;
		end
		else begin
			acc <= acc + step;
		end
	end

	// output register, top bits of the accumulator
	always_ff @(posedge clock) begin
		if (reset) begin
			interp_o <= '0;
		end
		else begin
			interp_o <= acc[`I_BITS-1 -: `OUT_BITS];
		end
	end

	// sticky, set when a boundary finds no sample
	always_ff @(posedge clock) begin
		if (reset) begin
			underrun <= 1'b0;
		end
		else if (boundary && empty) begin
			underrun <= 1'b1;
		end
	end

	// a pop happens only at the boundary
	a_pop_at_boundary: assert property (
		@(posedge clock) disable iff (reset)
		rd_en |-> (frame_cnt == FRAME_LAST)
	) else $error("linear_interp: pop outside the frame boundary");

endmodule

//--- logic/sample_fifo.sv
`timescale 1ns/10ps

`include "interp_cfg.svh"

module sample_fifo #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                wr_en,
	input  interp_pkg::sample_t wr_data,
	input  logic                rd_en,
	output interp_pkg::sample_t rd_data,
	output logic                full,
	output logic                empty
);

	import interp_pkg::*;

	// pointer and count widths
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	// last slot before the pointers wrap
	localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
	// occupancy at which the fifo reports full
	localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(DEPTH);

	// ring storage
	sample_t mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;

	// accepted operations this cycle
	logic do_wr;
	logic do_rd;

	// a write into a full fifo is dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clock) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// write pointer, wraps at DEPTH
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
		end
		else if (do_wr) begin
			wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
		end
	end

	// read pointer, head moves on after a pop
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr <= '0;
		end
		else if (do_rd) begin
			rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
		end
	end

	// occupancy
	// simultaneous read and write leaves it unchanged
	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end
		else begin
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// flags straight from the count
	assign full  = (count == FULL_CNT);
	assign empty = (count == '0);

	// show-ahead, head entry always visible
	assign rd_data = mem[rd_ptr];

	// consumer only pops when it has seen data present
	a_no_pop_empty: assert property (
		@(posedge clock) disable iff (reset)
		rd_en |-> !empty
	) else $error("sample_fifo: read requested while empty");

	// occupancy bounded by the storage size
	a_count_bound: assert property (
		@(posedge clock) disable iff (reset)
		count <= FULL_CNT
	) else $error("sample_fifo: count above depth");

endmodule

//--- logic/sample_capture.sv
`timescale 1ns/10ps

`include "interp_cfg.svh"

module sample_capture (
	input  logic                  clock,
	input  logic                  reset,
	input  interp_pkg::in_sample_t v_in,
	input  logic                  sample_valid,
	input  logic                  full,
	output logic                  wr_en,
	output interp_pkg::sample_t   wr_data,
	output logic                  overflow
);

	import interp_pkg::*;

	// input moved to the top of the internal word
	sample_t aligned;

	// zero fill below the raw sample bits
	assign aligned = {v_in, {(`I_BITS - `IN_BITS){1'b0}}};

	// write strobe follows the input strobe by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_en <= 1'b0;
		end
		else begin
			wr_en <= sample_valid;
		end
	end

	// sample held until the next strobe
	always_ff @(posedge clock) begin
		if (sample_valid) begin
			wr_data <= aligned;
		end
	end

	// sticky, a write that meets a full fifo is lost
	// only reset clears it
	always_ff @(posedge clock) begin
		if (reset) begin
			overflow <= 1'b0;
		end
		else if (wr_en && full) begin
			overflow <= 1'b1;
		end
	end

	// strobes are at least two cycles apart,
	// so every write is a single-cycle pulse
	a_single_write: assert property (
		@(posedge clock) disable iff (reset)
		wr_en |=> !wr_en
	) else $error("sample_capture: write strobe held for two cycles");

endmodule

//--- logic/interp_pkg.sv
`include "interp_cfg.svh"

package interp_pkg;

	// raw sample as it arrives from outside
	typedef logic signed [`IN_BITS-1:0] in_sample_t;

	// internal sample, input left-aligned
	// used by capture, fifo and interpolator alike
	typedef logic signed [`I_BITS-1:0] sample_t;

	// interpolated output word
	// top OUT_BITS of the accumulator
	typedef logic signed [`OUT_BITS-1:0] out_sample_t;

endpackage

//--- logic/interp_cfg.svh
`ifndef INTERP_CFG_SVH
`define INTERP_CFG_SVH

// width of a raw input sample
`define IN_BITS 8

// internal accumulator width
// an input sample sits left-aligned here, zero bits below it
`define I_BITS 16

// output width, the top bits of the accumulator
`define OUT_BITS 12

// log2 of the upsample factor
// one frame is 2**STEP_SHIFT clocks long
`define STEP_SHIFT 4

// entries in the sample fifo
`define FIFO_DEPTH 4

`endif
